/* bench/lc4_patterns.txt */
# insn rf_we wsel wdata nzp_we nzp dmem_we dmem_addr dmem_data, all hex
# line k is fetched from 8200h + k, a zero word retires as an empty slot
9005 1 0 0005 1 1 0 0000 0000
93FD 1 1 FFFD 1 4 0 0000 0000
1401 1 2 0002 1 1 0 0000 0000
1690 1 3 FFFD 1 4 0 0000 0000
9A00 1 5 0000 1 2 0 0000 0000
DB01 1 5 0100 1 1 0 0000 0000
1D4D 1 6 0000 1 2 0 0000 0000
1E4D 1 7 FD00 1 4 0 0000 0000
19FF 1 4 FCFF 1 4 0 0000 0000
5907 1 4 FC00 1 4 0 0000 0000
5C08 1 6 FFFA 1 4 0 0000 0000
5495 1 2 0102 1 1 0 0000 0000
56DB 1 3 0000 1 2 0 0000 0000
526F 1 1 000D 1 1 0 0000 0000
0000 0 0 0000 0 0 0 0000 0000
7543 0 0 0000 0 0 1 0103 0102
1027 1 0 000C 1 1 0 0000 0000
717E 0 0 0000 0 0 1 00FE 000C
6943 1 4 0102 1 1 0 0103 0102
6D7E 1 6 000C 1 1 0 00FE 000C
6FC0 1 7 A75A 1 4 0 FD00 A75A
1306 1 1 010E 1 1 0 0000 0000

/* bench/tb_lc4_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_pipeline;

   import lc4_pkg::*;

   localparam word_t PROG_BASE    = 16'h8200; // program word k sits at 8200h + k
   localparam int    CLK_PERIOD   = 40;
   localparam int    RESET_CYCLES = 10;
   localparam int    DRIVE_DELAY  = 2;

   // one pattern line holds the word and its expected writeback trace
   typedef struct packed {
      word_t      insn;
      logic       rf_we;
      logic [2:0] wsel;
      word_t      wdata;
      logic       nzp_we;
      logic [2:0] nzp;
      logic       dmem_we;
      word_t      daddr;
      word_t      ddata;
   } trace_line_t;

   logic     gwe;
   logic     reset;
   word_t    cur_pc;
   word_t    cur_insn;
   word_t    dmem_addr;
   word_t    dmem_towrite;
   word_t    dmem_rdata;
   logic     dmem_we;
   stall_t   test_stall;
   word_t    test_pc;
   word_t    test_insn;
   logic     test_regfile_we;
   reg_sel_t test_regfile_wsel;
   word_t    test_regfile_data;
   logic     test_nzp_we;
   nzp_t     test_nzp_new_bits;
   logic     test_dmem_we;
   word_t    test_dmem_addr;
   word_t    test_dmem_data;

   trace_line_t lines [$];
   word_t       dmem [0:65535];
   logic        loaded;
   int          line_idx;

   logic        port_we;    // data memory port seen while the slot sat in MEM
   word_t       port_addr;
   word_t       port_wdata;

   lc4_pipeline u_lc4_pipeline (
      .gwe(gwe), .i_reset(reset),
      .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
      .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_towrite(dmem_towrite),
      .i_cur_dmem_data(dmem_rdata),
      .o_test_stall(test_stall), .o_test_pc(test_pc), .o_test_insn(test_insn),
      .o_test_regfile_we(test_regfile_we), .o_test_regfile_wsel(test_regfile_wsel),
      .o_test_regfile_data(test_regfile_data),
      .o_test_nzp_we(test_nzp_we), .o_test_nzp_new_bits(test_nzp_new_bits),
      .o_test_dmem_we(test_dmem_we), .o_test_dmem_addr(test_dmem_addr),
      .o_test_dmem_data(test_dmem_data)
   );

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      assert (actual === expected) else begin
         $display("Mismatch %s expected %h got %h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "run aborted");
      end
   endtask

   task automatic load_patterns();
      int          fd;
      int          count;
      string       line;
      word_t       f_insn, f_rf_we, f_wsel, f_wdata, f_nzp_we, f_nzp, f_dwe, f_daddr, f_ddata;
      trace_line_t entry;
      fd = $fopen("bench/lc4_patterns.txt", "r");
      assert (fd != 0) else report_failure("cannot open bench/lc4_patterns.txt");
      while (!$feof(fd)) begin
         if ($fgets(line, fd) == 0) break;
         if (line.len() < 2 || line[0] == "#") continue; // blank or column notes
         count = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_insn, f_rf_we, f_wsel,
                         f_wdata, f_nzp_we, f_nzp, f_dwe, f_daddr, f_ddata);
         assert (count == 9) else report_failure({"malformed pattern line: ", line});
         entry.insn    = f_insn;
         entry.rf_we   = f_rf_we[0];
         entry.wsel    = f_wsel[2:0];
         entry.wdata   = f_wdata;
         entry.nzp_we  = f_nzp_we[0];
         entry.nzp     = f_nzp[2:0];
         entry.dmem_we = f_dwe[0];
         entry.daddr   = f_daddr;
         entry.ddata   = f_ddata;
         lines.push_back(entry);
      end
      $fclose(fd);
   endtask

   // instruction memory reads zero outside the program
   function automatic word_t fetch_word(input word_t addr);
      int offset;
      offset = int'(addr) - int'(PROG_BASE);
      if (offset >= 0 && offset < lines.size()) begin
         return lines[offset].insn;
      end
      return '0;
   endfunction

   // zero words retire as empty slots and have no trace to match
   function automatic int next_real_line(input int from);
      int idx;
      idx = from;
      while (idx < lines.size() && lines[idx].insn == '0) begin
         idx++;
      end
      return idx;
   endfunction

   task automatic check_retired(input int idx);
      trace_line_t want;
      want = lines[idx];
      check_value("o_test_pc", 16'(int'(PROG_BASE) + idx), test_pc);
      check_value("o_test_insn", want.insn, test_insn);
      check_value("o_test_regfile_we", 16'(want.rf_we), 16'(test_regfile_we));
      if (want.rf_we) begin // select and data only mean something on a write
         check_value("o_test_regfile_wsel", 16'(want.wsel), 16'(test_regfile_wsel));
         check_value("o_test_regfile_data", want.wdata, test_regfile_data);
      end
      check_value("o_test_nzp_we", 16'(want.nzp_we), 16'(test_nzp_we));
      check_value("o_test_nzp_new_bits", 16'(want.nzp), 16'(test_nzp_new_bits));
      check_value("o_test_dmem_we", 16'(want.dmem_we), 16'(test_dmem_we));
      check_value("o_test_dmem_addr", want.daddr, test_dmem_addr);
      check_value("o_test_dmem_data", want.ddata, test_dmem_data);
      check_value("o_dmem_we", 16'(want.dmem_we), 16'(port_we));
      if (want.dmem_we) begin
         check_value("o_dmem_addr", want.daddr, port_addr);
         check_value("o_dmem_towrite", want.ddata, port_wdata);
      end
   endtask

   task automatic check_empty_slot();
      check_value("o_test_regfile_we", 16'h0000, 16'(test_regfile_we));
      check_value("o_test_nzp_we", 16'h0000, 16'(test_nzp_we));
      check_value("o_test_dmem_we", 16'h0000, 16'(test_dmem_we));
      check_value("o_dmem_we", 16'h0000, 16'(port_we));
   endtask

   initial begin
      gwe = 1'b0;
      forever #(CLK_PERIOD / 2) gwe = ~gwe;
   end

   initial begin : drive_inputs
      int edges;
      edges      = 0;
      reset      = 1'b1;
      cur_insn   = '0;
      dmem_rdata = '0;
      forever begin
         @(posedge gwe);
         #DRIVE_DELAY;
         edges++;
         if (edges == RESET_CYCLES) begin
            reset = 1'b0;
         end
         cur_insn   = fetch_word(cur_pc);   // pc and dmem address only move at the edge
         dmem_rdata = dmem[dmem_addr];
      end
   end

   always @(posedge gwe) begin
      if (dmem_we) begin
         dmem[dmem_addr] = dmem_towrite; // read back only after the drive delay
      end
   end

   initial begin : main_seq
      loaded     = 1'b0;
      port_we    = 1'b0;
      port_addr  = '0;
      port_wdata = '0;
      for (int a = 0; a < 65536; a++) begin
         dmem[a] = 16'(a) ^ 16'h5A5A;
      end
      load_patterns();
      loaded   = 1'b1;
      line_idx = next_real_line(0);
      @(negedge reset);
      while (line_idx < lines.size()) begin
         @(negedge gwe); // trace is stable mid-cycle
         assert (test_stall == STALL_NONE || test_stall == STALL_EMPTY) else
            report_failure($sformatf("unknown stall code %0d in the trace", test_stall));
         if (test_stall == STALL_NONE) begin
            check_retired(line_idx);
            line_idx = next_real_line(line_idx + 1);
         end else begin
            check_empty_slot();
         end
         port_we    = dmem_we;      // this slot reaches writeback at the next sample
         port_addr  = dmem_addr;
         port_wdata = dmem_towrite;
      end
      $display("Test completed successfully");
      $finish;
   end

   // reset, program length, pipeline depth and some slack
   initial begin : watchdog
      wait (loaded);
      #((RESET_CYCLES + lines.size() + 4 + 20) * CLK_PERIOD);
      report_failure("trace ended before all instructions retired");
   end

endmodule

`default_nettype wire

/* filelist.f */
src/lc4_pkg.sv
src/lc4_decoder.sv
src/lc4_regfile.sv
src/lc4_bypass.sv
src/lc4_alu.sv
src/lc4_pipeline.sv
bench/tb_lc4_pipeline.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the LC4 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f --top-module tb_lc4_pipeline -o sim_lc4

sim_out=$(./obj_dir/sim_lc4 2>&1) || true
echo "$sim_out"

if grep -q "Test completed successfully" <<< "$sim_out"; then
   exit 0
fi
exit 1

/* src/lc4_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_alu (
   input  wire lc4_pkg::alu_op_e i_op,
   input  wire lc4_pkg::word_t   i_rs,
   input  wire lc4_pkg::word_t   i_rt,
   input  wire lc4_pkg::word_t   i_imm,
   input  wire                   i_use_imm,
   output lc4_pkg::word_t        o_result
);

   import lc4_pkg::*;

   word_t opb; // second operand, register or immediate

   assign opb = i_use_imm ? i_imm : i_rt;

   // all results wrap at 16 bits
   always_comb begin
      case (i_op)
         ALU_ADD: begin
            o_result = i_rs + opb;
         end
         ALU_MUL: begin
            o_result = i_rs * opb;  // low half of the product
         end
         ALU_SUB: begin
            o_result = i_rs - opb;
         end
         ALU_AND: begin
            o_result = i_rs & opb;
         end
         ALU_NOT: begin
            o_result = ~i_rs;
         end
         ALU_OR: begin
            o_result = i_rs | opb;
         end
         ALU_XOR: begin
            o_result = i_rs ^ opb;
         end
         ALU_CONST: begin
            o_result = i_imm;
         end
         ALU_HICONST: begin
            o_result = {i_imm[7:0], i_rs[7:0]};
         end
         ALU_PASS: begin
            // effective address for LDR and STR
            o_result = i_rs + i_imm;
         end
         default: begin
            o_result = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* src/lc4_bypass.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_bypass (
   input  wire lc4_pkg::reg_sel_t i_src_sel,  // operand register in EX
   input  wire lc4_pkg::word_t    i_src_data, // value read in decode

   input  wire                    i_mem_we,
   input  wire lc4_pkg::reg_sel_t i_mem_sel,
   input  wire lc4_pkg::word_t    i_mem_data,

   input  wire                    i_wb_we,
   input  wire lc4_pkg::reg_sel_t i_wb_sel,
   input  wire lc4_pkg::word_t    i_wb_data,

   output lc4_pkg::word_t         o_data
);

   logic mem_hit;
   logic wb_hit;

   assign mem_hit = i_mem_we && (i_mem_sel == i_src_sel); // distance one
   assign wb_hit  = i_wb_we && (i_wb_sel == i_src_sel);   // distance two

   // youngest producer first
   always_comb begin
      if (mem_hit) begin
         o_data = i_mem_data;
      end else if (wb_hit) begin
         o_data = i_wb_data;
      end else begin
         o_data = i_src_data;
      end
   end

endmodule

`default_nettype wire

/* src/lc4_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder (
   input  wire lc4_pkg::word_t i_insn,
   output lc4_pkg::reg_sel_t   o_rs_sel,
   output lc4_pkg::reg_sel_t   o_rt_sel,
   output lc4_pkg::reg_sel_t   o_rd_sel,
   output logic                o_rs_re,
   output logic                o_rt_re,
   output logic                o_regfile_we,
   output logic                o_nzp_we,
   output logic                o_is_load,
   output logic                o_is_store,
   output lc4_pkg::alu_op_e    o_alu_op,
   output logic                o_use_imm,
   output lc4_pkg::word_t      o_imm
);

   import lc4_pkg::*;

   opcode_e    opcode;
   logic [1:0] sub_op;  // register-form sub-op, bit 5 picks the imm5 form
   word_t      imm5;
   word_t      imm6;
   word_t      imm9;
   word_t      uimm8;

   assign opcode = opcode_e'(i_insn[15:12]);
   assign sub_op = i_insn[4:3];
   assign imm5   = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6   = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9   = {{7{i_insn[8]}}, i_insn[8:0]};
   assign uimm8  = {8'h00, i_insn[7:0]};

   always_comb begin
      // field positions shared by most formats
      o_rs_sel     = i_insn[8:6];
      o_rt_sel     = i_insn[2:0];
      o_rd_sel     = i_insn[11:9];
      o_rs_re      = 1'b0;
      o_rt_re      = 1'b0;
      o_regfile_we = 1'b0;
      o_nzp_we     = 1'b0;
      o_is_load    = 1'b0;
      o_is_store   = 1'b0;
      o_alu_op     = ALU_PASS;
      o_use_imm    = 1'b0;
      o_imm        = '0;

      case (opcode)
         OP_ARITH, OP_LOGIC: begin
            o_rs_re = 1'b1;
            if (i_insn[5]) begin            // immediate form: ADD or AND with imm5
               o_alu_op     = (opcode == OP_ARITH) ? ALU_ADD : ALU_AND;
               o_use_imm    = 1'b1;
               o_imm        = imm5;
               o_regfile_we = 1'b1;
            end else if (opcode == OP_ARITH) begin
               o_rt_re      = 1'b1;
               o_regfile_we = (sub_op != 2'b11); // DIV not supported
               case (sub_op)
                  2'b00:   o_alu_op = ALU_ADD;
                  2'b01:   o_alu_op = ALU_MUL;
                  default: o_alu_op = ALU_SUB;
               endcase
            end else begin
               o_rt_re      = (sub_op != 2'b01); // NOT has one source
               o_regfile_we = 1'b1;
               case (sub_op)
                  2'b00:   o_alu_op = ALU_AND;
                  2'b01:   o_alu_op = ALU_NOT;
                  2'b10:   o_alu_op = ALU_OR;
                  default: o_alu_op = ALU_XOR;
               endcase
            end
            o_nzp_we = o_regfile_we;
         end
         OP_LDR: begin
            o_rs_re      = 1'b1;
            o_use_imm    = 1'b1;
            o_imm        = imm6;
            o_is_load    = 1'b1;
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;
         end
         OP_STR: begin
            o_rt_sel   = i_insn[11:9]; // store data comes from the rd field
            o_rs_re    = 1'b1;
            o_rt_re    = 1'b1;
            o_use_imm  = 1'b1;
            o_imm      = imm6;
            o_is_store = 1'b1;
         end
         OP_CONST: begin
            o_alu_op     = ALU_CONST;
            o_use_imm    = 1'b1;
            o_imm        = imm9;
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;
         end
         OP_HICONST: begin
            o_rs_sel     = i_insn[11:9];  // low byte of rd is kept
            o_rs_re      = i_insn[8];
            o_alu_op     = ALU_HICONST;
            o_use_imm    = 1'b1;
            o_imm        = uimm8;
            o_regfile_we = i_insn[8];
            o_nzp_we     = i_insn[8];
         end
         OP_BR: ;  // zero word, nothing to do
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* src/lc4_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_pipeline (
   input  wire                 gwe,
   input  wire                 i_reset,

   output lc4_pkg::word_t      o_cur_pc,       // instruction memory address
   input  wire lc4_pkg::word_t i_cur_insn,

   output lc4_pkg::word_t      o_dmem_addr,
   output logic                o_dmem_we,
   output lc4_pkg::word_t      o_dmem_towrite,
   input  wire lc4_pkg::word_t i_cur_dmem_data,

   // writeback-stage trace
   output lc4_pkg::stall_t     o_test_stall,
   output lc4_pkg::word_t      o_test_pc,
   output lc4_pkg::word_t      o_test_insn,
   output logic                o_test_regfile_we,
   output lc4_pkg::reg_sel_t   o_test_regfile_wsel,
   output lc4_pkg::word_t      o_test_regfile_data,
   output logic                o_test_nzp_we,
   output lc4_pkg::nzp_t       o_test_nzp_new_bits,
   output logic                o_test_dmem_we,
   output lc4_pkg::word_t      o_test_dmem_addr,
   output lc4_pkg::word_t      o_test_dmem_data
);

   import lc4_pkg::*;

   // fetch
   word_t  f_pc;
   stall_t f_stall;

   // decode
   word_t    d_pc, d_insn;
   stall_t   d_stall;
   logic     d_valid;
   reg_sel_t d_rs_sel, d_rt_sel, d_rd_sel;
   logic     d_rs_re, d_rt_re, d_regfile_we, d_nzp_we, d_is_load, d_is_store;
   alu_op_e  d_alu_op;
   logic     d_use_imm;
   word_t    d_imm, d_rs_data, d_rt_data;

   // execute
   word_t    x_pc, x_insn, x_rs_data, x_rt_data, x_imm;
   stall_t   x_stall;
   reg_sel_t x_rs_sel, x_rt_sel, x_rd_sel;
   logic     x_rs_re, x_rt_re, x_regfile_we, x_nzp_we, x_is_load, x_is_store;
   alu_op_e  x_alu_op;
   logic     x_use_imm;
   word_t    x_rs_fwd, x_rt_fwd, x_rs_val, x_rt_val, x_alu_result;

   // memory
   word_t    m_pc, m_insn, m_alu_result, m_rt_data;
   stall_t   m_stall;
   reg_sel_t m_rd_sel;
   logic     m_regfile_we, m_nzp_we, m_is_load, m_is_store;
   word_t    m_rd_data, m_dmem_addr, m_dmem_data;
   nzp_t     m_nzp, nzp_q;

   // writeback
   word_t    w_pc, w_insn, w_rd_data, w_dmem_addr, w_dmem_data;
   stall_t   w_stall;
   reg_sel_t w_rd_sel;
   logic     w_regfile_we, w_nzp_we, w_dmem_we;

   assign o_cur_pc = f_pc;
   assign f_stall  = (i_cur_insn == '0) ? STALL_EMPTY : STALL_NONE; // zero word is a bubble

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         f_pc <= RESET_PC;
      end else begin
         f_pc <= f_pc + 16'd1;
      end
   end

   lc4_decoder u_decoder (
      .i_insn(d_insn), .o_rs_sel(d_rs_sel), .o_rt_sel(d_rt_sel), .o_rd_sel(d_rd_sel),
      .o_rs_re(d_rs_re), .o_rt_re(d_rt_re), .o_regfile_we(d_regfile_we),
      .o_nzp_we(d_nzp_we), .o_is_load(d_is_load), .o_is_store(d_is_store),
      .o_alu_op(d_alu_op), .o_use_imm(d_use_imm), .o_imm(d_imm)
   );

   lc4_regfile u_regfile (
      .gwe(gwe), .i_reset(i_reset),
      .i_rs_sel(d_rs_sel), .i_rt_sel(d_rt_sel), .i_rd_sel(w_rd_sel),
      .i_wdata(w_rd_data), .i_we(w_regfile_we),
      .o_rs_data(d_rs_data), .o_rt_data(d_rt_data)
   );

   // IF/ID holds a stale word during reset, so enables follow the stall code
   assign d_valid = (d_stall == STALL_NONE);

   lc4_bypass u_bypass_rs (
      .i_src_sel(x_rs_sel), .i_src_data(x_rs_data),
      .i_mem_we(m_regfile_we), .i_mem_sel(m_rd_sel), .i_mem_data(m_rd_data),
      .i_wb_we(w_regfile_we), .i_wb_sel(w_rd_sel), .i_wb_data(w_rd_data),
      .o_data(x_rs_fwd)
   );

   lc4_bypass u_bypass_rt (
      .i_src_sel(x_rt_sel), .i_src_data(x_rt_data),
      .i_mem_we(m_regfile_we), .i_mem_sel(m_rd_sel), .i_mem_data(m_rd_data),
      .i_wb_we(w_regfile_we), .i_wb_sel(w_rd_sel), .i_wb_data(w_rd_data),
      .o_data(x_rt_fwd)
   );

   assign x_rs_val = x_rs_re ? x_rs_fwd : '0; // unused operands read as zero
   assign x_rt_val = x_rt_re ? x_rt_fwd : '0;

   lc4_alu u_alu (
      .i_op(x_alu_op), .i_rs(x_rs_val), .i_rt(x_rt_val), .i_imm(x_imm),
      .i_use_imm(x_use_imm), .o_result(x_alu_result)
   );

   // memory stage
   assign m_rd_data      = m_is_load ? i_cur_dmem_data : m_alu_result;
   assign m_dmem_addr    = (m_is_load || m_is_store) ? m_alu_result : '0;
   assign m_dmem_data    = m_is_load ? i_cur_dmem_data : (m_is_store ? m_rt_data : '0);
   assign o_dmem_addr    = m_dmem_addr;
   assign o_dmem_we      = m_is_store;
   assign o_dmem_towrite = m_rt_data;

   always_comb begin
      if (m_rd_data == '0) begin
         m_nzp = 3'b010;
      end else if (m_rd_data[WORD_W-1]) begin
         m_nzp = 3'b100;
      end else begin
         m_nzp = 3'b001;
      end
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         nzp_q <= '0;
      end else if (m_nzp_we) begin
         nzp_q <= m_nzp;
      end
   end

   // pipeline control
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         d_stall      <= STALL_EMPTY;
         x_stall      <= STALL_EMPTY;
         m_stall      <= STALL_EMPTY;
         w_stall      <= STALL_EMPTY;
         x_regfile_we <= 1'b0;
         x_nzp_we     <= 1'b0;
         x_is_load    <= 1'b0;
         x_is_store   <= 1'b0;
         m_regfile_we <= 1'b0;
         m_nzp_we     <= 1'b0;
         m_is_load    <= 1'b0;
         m_is_store   <= 1'b0;
         w_regfile_we <= 1'b0;
         w_nzp_we     <= 1'b0;
         w_dmem_we    <= 1'b0;
      end else begin
         d_stall      <= f_stall;
         x_stall      <= d_stall;
         m_stall      <= x_stall;
         w_stall      <= m_stall;
         x_regfile_we <= d_valid & d_regfile_we;
         x_nzp_we     <= d_valid & d_nzp_we;
         x_is_load    <= d_valid & d_is_load;
         x_is_store   <= d_valid & d_is_store;
         m_regfile_we <= x_regfile_we;
         m_nzp_we     <= x_nzp_we;
         m_is_load    <= x_is_load;
         m_is_store   <= x_is_store;
         w_regfile_we <= m_regfile_we;
         w_nzp_we     <= m_nzp_we;
         w_dmem_we    <= m_is_store;
      end
   end

   // pipeline payload
   always_ff @(posedge gwe) begin
      d_pc         <= f_pc;
      d_insn       <= i_cur_insn;

      x_pc         <= d_pc;
      x_insn       <= d_insn;
      x_rs_sel     <= d_rs_sel;
      x_rt_sel     <= d_rt_sel;
      x_rd_sel     <= d_rd_sel;
      x_rs_re      <= d_rs_re;
      x_rt_re      <= d_rt_re;
      x_rs_data    <= d_rs_data;
      x_rt_data    <= d_rt_data;
      x_alu_op     <= d_alu_op;
      x_use_imm    <= d_use_imm;
      x_imm        <= d_imm;

      m_pc         <= x_pc;
      m_insn       <= x_insn;
      m_rd_sel     <= x_rd_sel;
      m_alu_result <= x_alu_result;
      m_rt_data    <= x_rt_val;      // forwarded store data

      w_pc         <= m_pc;
      w_insn       <= m_insn;
      w_rd_sel     <= m_rd_sel;
      w_rd_data    <= m_rd_data;
      w_dmem_addr  <= m_dmem_addr;
      w_dmem_data  <= m_dmem_data;
   end

   // trace
   assign o_test_stall        = w_stall;
   assign o_test_pc           = w_pc;
   assign o_test_insn         = w_insn;
   assign o_test_regfile_we   = w_regfile_we;
   assign o_test_regfile_wsel = w_rd_sel;
   assign o_test_regfile_data = w_rd_data;
   assign o_test_nzp_we       = w_nzp_we;
   assign o_test_nzp_new_bits = w_nzp_we ? nzp_q : '0; // nzp_q was loaded as this insn left MEM
   assign o_test_dmem_we      = w_dmem_we;
   assign o_test_dmem_addr    = w_dmem_addr;
   assign o_test_dmem_data    = w_dmem_data;

endmodule

`default_nettype wire

/* src/lc4_pkg.sv */
`default_nettype none

package lc4_pkg;

   // machine widths, fixed by the ISA
   localparam int WORD_W    = 16;
   localparam int REG_SEL_W = 3;
   localparam int NUM_REGS  = 8;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_SEL_W-1:0] reg_sel_t;
   typedef logic [2:0]           nzp_t;    // {n, z, p}, one-hot
   typedef logic [1:0]           stall_t;

   localparam word_t RESET_PC = 16'h8200; // first fetch after reset

   // trace stall codes
   localparam stall_t STALL_NONE  = 2'd0; // real instruction
   localparam stall_t STALL_EMPTY = 2'd2; // reset bubble or zero word

   // top four bits of the instruction word
   typedef enum logic [3:0] {
      OP_BR      = 4'b0000, // only the all-zero word reaches us here
      OP_ARITH   = 4'b0001,
      OP_LOGIC   = 4'b0101,
      OP_LDR     = 4'b0110,
      OP_STR     = 4'b0111,
      OP_CONST   = 4'b1001,
      OP_HICONST = 4'b1101
   } opcode_e;

   // operation carried from decode into the ALU
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_MUL,
      ALU_SUB,
      ALU_AND,
      ALU_NOT,
      ALU_OR,
      ALU_XOR,
      ALU_CONST,
      ALU_HICONST,
      ALU_PASS   // rs + imm, load/store address
   } alu_op_e;

endpackage

`default_nettype wire

/* src/lc4_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile (
   input  wire                    gwe,
   input  wire                    i_reset,
   input  wire lc4_pkg::reg_sel_t i_rs_sel,
   input  wire lc4_pkg::reg_sel_t i_rt_sel,
   input  wire lc4_pkg::reg_sel_t i_rd_sel,
   input  wire lc4_pkg::word_t    i_wdata,
   input  wire                    i_we,
   output lc4_pkg::word_t         o_rs_data,
   output lc4_pkg::word_t         o_rt_data
);

   import lc4_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd_sel] <= i_wdata;
      end
   end

   // a read of the register written this cycle sees the new value
   assign o_rs_data = (i_we && (i_rd_sel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = (i_we && (i_rd_sel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

`default_nettype wire
